// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= rv_core_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT := ALL CHECKS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
logic/rv_pkg.sv
logic/register_file.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/writeback_unit.sv
logic/rv_core.sv
verif/rv_core_assertions.sv
verif/rv_core_tb.sv

// ==== logic/decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
	input  wire               clock,
	input  wire               reset,
	input  wire rv_pkg::word_t if_pc,
	input  wire rv_pkg::word_t if_instr,
	input  wire               redirect,
	input  wire rv_pkg::reg_addr_t wb_rd,
	input  wire               wb_we,
	input  wire rv_pkg::word_t wb_data,
	output logic              stall,
	output rv_pkg::word_t     id_pc,
	output rv_pkg::reg_addr_t id_rs1,
	output rv_pkg::reg_addr_t id_rs2,
	output rv_pkg::reg_addr_t id_rd,
	output rv_pkg::word_t     id_a,
	output rv_pkg::word_t     id_b,
	output rv_pkg::word_t     id_imm,
	output rv_pkg::alu_op_t   id_alu_op,
	output logic              id_use_imm,
	output logic              id_branch,
	output logic              id_jal,
	output logic              id_mem_read,
	output logic              id_mem_write,
	output logic              id_reg_write
);

	rv_pkg::instr_u  ins;
	rv_pkg::word_t   rf_a;
	rv_pkg::word_t   rf_b;
	rv_pkg::word_t   imm;
	rv_pkg::alu_op_t alu_op;
	logic [6:0]      opcode;
	logic            use_imm;
	logic            is_branch;
	logic            is_jal;
	logic            mem_read;
	logic            mem_write;
	logic            reg_write;
	logic            uses_rs1;
	logic            uses_rs2;
	logic            insert_bubble;

	assign ins    = if_instr;
	assign opcode = ins.r_fields.opcode;

	register_file i_register_file (
		.clock (clock),
		.reset (reset),
		.ra    (ins.r_fields.rs1),
		.rb    (ins.r_fields.rs2),
		.wa    (wb_rd),
		.we    (wb_we),
		.wd    (wb_data),
		.rd_a  (rf_a),
		.rd_b  (rf_b)
	);

	always_comb begin
		use_imm   = 1'b0;
		is_branch = 1'b0;
		is_jal    = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		reg_write = 1'b0;
		uses_rs1  = 1'b0;
		uses_rs2  = 1'b0;
		alu_op    = rv_pkg::alu_add;
		case (opcode)
			rv_pkg::op_reg: begin
				uses_rs1  = 1'b1;
				uses_rs2  = 1'b1;
				reg_write = 1'b1;
				case (ins.r_fields.funct3)
					rv_pkg::f3_add_sub: begin
						alu_op = ins.r_fields.funct7[5] ? rv_pkg::alu_sub : rv_pkg::alu_add;
					end
					rv_pkg::f3_slt: alu_op = rv_pkg::alu_slt;
					rv_pkg::f3_xor: alu_op = rv_pkg::alu_xor;
					rv_pkg::f3_or: alu_op = rv_pkg::alu_or;
					rv_pkg::f3_and: alu_op = rv_pkg::alu_and;
					default: alu_op = rv_pkg::alu_add;
				endcase
			end
			rv_pkg::op_imm: begin
				uses_rs1  = 1'b1;
				use_imm   = 1'b1;
				reg_write = 1'b1;
			end
			rv_pkg::op_load: begin
				uses_rs1  = 1'b1;
				use_imm   = 1'b1;
				mem_read  = 1'b1;
				reg_write = 1'b1;
			end
			rv_pkg::op_store: begin
				uses_rs1  = 1'b1;
				uses_rs2  = 1'b1;
				use_imm   = 1'b1;
				mem_write = 1'b1;
			end
			rv_pkg::op_branch: begin
				uses_rs1  = 1'b1;
				uses_rs2  = 1'b1;
				is_branch = (ins.r_fields.funct3 == rv_pkg::f3_beq);
			end
			rv_pkg::op_jal: begin
				is_jal    = 1'b1;
				reg_write = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// S, B and J immediates are scattered over the raw word
	always_comb begin
		case (opcode)
			rv_pkg::op_store: begin
				imm = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
			end
			rv_pkg::op_branch: begin
				imm = {{20{if_instr[31]}}, if_instr[7], if_instr[30:25],
					if_instr[11:8], 1'b0};
			end
			rv_pkg::op_jal: begin
				imm = {{12{if_instr[31]}}, if_instr[19:12], if_instr[20],
					if_instr[30:21], 1'b0};
			end
			default: begin
				imm = {{20{ins.i_fields.imm12[11]}}, ins.i_fields.imm12};
			end
		endcase
	end

	// load now in execute feeds this instruction
	assign stall = id_mem_read && (id_rd != '0) &&
		((uses_rs1 && id_rd == ins.r_fields.rs1) ||
		(uses_rs2 && id_rd == ins.r_fields.rs2));

	assign insert_bubble = stall || redirect;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			id_branch    <= 1'b0;
			id_jal       <= 1'b0;
			id_mem_read  <= 1'b0;
			id_mem_write <= 1'b0;
			id_reg_write <= 1'b0;
		end else begin
			id_branch    <= is_branch && !insert_bubble;
			id_jal       <= is_jal && !insert_bubble;
			id_mem_read  <= mem_read && !insert_bubble;
			id_mem_write <= mem_write && !insert_bubble;
			id_reg_write <= reg_write && !insert_bubble;
		end
	end

	always_ff @(posedge clock) begin
		id_pc      <= if_pc;
		id_rs1     <= ins.r_fields.rs1;
		id_rs2     <= ins.r_fields.rs2;
		id_rd      <= ins.r_fields.rd;
		id_a       <= rf_a;
		id_b       <= rf_b;
		id_imm     <= imm;
		id_alu_op  <= alu_op;
		id_use_imm <= use_imm;
	end

endmodule

`default_nettype wire

// ==== logic/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  wire               clock,
	input  wire               reset,
	input  wire rv_pkg::word_t id_pc,
	input  wire rv_pkg::reg_addr_t id_rs1,
	input  wire rv_pkg::reg_addr_t id_rs2,
	input  wire rv_pkg::reg_addr_t id_rd,
	input  wire rv_pkg::word_t id_a,
	input  wire rv_pkg::word_t id_b,
	input  wire rv_pkg::word_t id_imm,
	input  wire rv_pkg::alu_op_t id_alu_op,
	input  wire               id_use_imm,
	input  wire               id_branch,
	input  wire               id_jal,
	input  wire               id_mem_read,
	input  wire               id_mem_write,
	input  wire               id_reg_write,
	input  wire rv_pkg::reg_addr_t wb_rd,
	input  wire               wb_we,
	input  wire rv_pkg::word_t wb_data,
	output logic              redirect,
	output rv_pkg::word_t     redirect_pc,
	output rv_pkg::word_t     ex_result,
	output rv_pkg::word_t     ex_store_data,
	output rv_pkg::reg_addr_t ex_rd,
	output logic              ex_reg_write,
	output logic              ex_mem_read,
	output logic              ex_mem_write
);

	rv_pkg::word_t opnd_a;
	rv_pkg::word_t fwd_b;
	rv_pkg::word_t opnd_b;
	rv_pkg::word_t alu_out;
	rv_pkg::word_t result;

	// newest producer wins, a load still in memory is left to the decode stall
	function automatic rv_pkg::word_t forward(input rv_pkg::reg_addr_t rs,
		input rv_pkg::word_t reg_val);
		if (ex_reg_write && !ex_mem_read && ex_rd != '0 && ex_rd == rs) begin
			return ex_result;
		end else if (wb_we && wb_rd != '0 && wb_rd == rs) begin
			return wb_data;
		end
		return reg_val;
	endfunction

	always_comb begin
		opnd_a = forward(id_rs1, id_a);
		fwd_b  = forward(id_rs2, id_b);
	end

	assign opnd_b = id_use_imm ? id_imm : fwd_b;

	always_comb begin
		case (id_alu_op)
			rv_pkg::alu_sub: alu_out = opnd_a - opnd_b;
			rv_pkg::alu_and: alu_out = opnd_a & opnd_b;
			rv_pkg::alu_or: alu_out = opnd_a | opnd_b;
			rv_pkg::alu_xor: alu_out = opnd_a ^ opnd_b;
			rv_pkg::alu_slt: alu_out = rv_pkg::word_t'($signed(opnd_a) < $signed(opnd_b));
			default: alu_out = opnd_a + opnd_b;
		endcase
	end

	// jal writes the link address
	assign result = id_jal ? id_pc + 32'd4 : alu_out;

	// beq and jal share one target adder
	assign redirect    = id_jal || (id_branch && opnd_a == fwd_b);
	assign redirect_pc = id_pc + id_imm;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ex_reg_write <= 1'b0;
			ex_mem_read  <= 1'b0;
			ex_mem_write <= 1'b0;
		end else begin
			ex_reg_write <= id_reg_write;
			ex_mem_read  <= id_mem_read;
			ex_mem_write <= id_mem_write;
		end
	end

	always_ff @(posedge clock) begin
		ex_result     <= result;
		ex_store_data <= fwd_b;
		ex_rd         <= id_rd;
	end

endmodule

`default_nettype wire

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  wire           clock,
	input  wire           reset,
	input  wire rv_pkg::word_t instr,
	input  wire           stall,
	input  wire           redirect,
	input  wire rv_pkg::word_t redirect_pc,
	output rv_pkg::word_t pc,
	output rv_pkg::word_t if_pc,
	output rv_pkg::word_t if_instr
);

	// redirect wins over a load-use hold
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= rv_pkg::initial_pc;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (!stall) begin
			pc <= pc + 32'd4;
		end
	end

	// fetch/decode register, the word in flight is dropped on redirect
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			if_pc    <= rv_pkg::initial_pc;
			if_instr <= rv_pkg::nop_instr;
		end else if (redirect) begin
			if_pc    <= pc;
			if_instr <= rv_pkg::nop_instr;
		end else if (!stall) begin
			if_pc    <= pc;
			if_instr <= instr;
		end
	end

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  wire               clock,
	input  wire               reset,
	input  wire rv_pkg::reg_addr_t ra,
	input  wire rv_pkg::reg_addr_t rb,
	input  wire rv_pkg::reg_addr_t wa,
	input  wire               we,
	input  wire rv_pkg::word_t wd,
	output rv_pkg::word_t     rd_a,
	output rv_pkg::word_t     rd_b
);

	rv_pkg::word_t regs [32];

	// x0 is never written so it reads zero
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// value written this cycle shows up on the read ports
	assign rd_a = (we && wa != '0 && wa == ra) ? wd : regs[ra];
	assign rd_b = (we && wa != '0 && wa == rb) ? wd : regs[rb];

endmodule

`default_nettype wire

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core (
	input  wire           clock,
	input  wire           reset,
	output rv_pkg::word_t pc,
	input  wire rv_pkg::word_t instr,
	output rv_pkg::word_t data_addr,
	output rv_pkg::word_t data_out,
	input  wire rv_pkg::word_t data_in,
	output logic          ren,
	output logic          wen
);

	// fetch to decode
	rv_pkg::word_t     if_pc;
	rv_pkg::word_t     if_instr;
	logic              stall;

	// decode to execute
	rv_pkg::word_t     id_pc;
	rv_pkg::reg_addr_t id_rs1;
	rv_pkg::reg_addr_t id_rs2;
	rv_pkg::reg_addr_t id_rd;
	rv_pkg::word_t     id_a;
	rv_pkg::word_t     id_b;
	rv_pkg::word_t     id_imm;
	rv_pkg::alu_op_t   id_alu_op;
	logic              id_use_imm;
	logic              id_branch;
	logic              id_jal;
	logic              id_mem_read;
	logic              id_mem_write;
	logic              id_reg_write;

	// redirect back to the front end
	logic              redirect;
	rv_pkg::word_t     redirect_pc;

	// memory stage
	rv_pkg::word_t     ex_result;
	rv_pkg::reg_addr_t ex_rd;
	logic              ex_reg_write;
	logic              ex_mem_read;

	// writeback
	rv_pkg::reg_addr_t wb_rd;
	logic              wb_we;
	rv_pkg::word_t     wb_data;

	assign data_addr = ex_result;
	assign ren       = ex_mem_read;

	fetch_unit i_fetch_unit (
		.clock       (clock),
		.reset       (reset),
		.instr       (instr),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.pc          (pc),
		.if_pc       (if_pc),
		.if_instr    (if_instr)
	);

	decode_unit i_decode_unit (
		.clock        (clock),
		.reset        (reset),
		.if_pc        (if_pc),
		.if_instr     (if_instr),
		.redirect     (redirect),
		.wb_rd        (wb_rd),
		.wb_we        (wb_we),
		.wb_data      (wb_data),
		.stall        (stall),
		.id_pc        (id_pc),
		.id_rs1       (id_rs1),
		.id_rs2       (id_rs2),
		.id_rd        (id_rd),
		.id_a         (id_a),
		.id_b         (id_b),
		.id_imm       (id_imm),
		.id_alu_op    (id_alu_op),
		.id_use_imm   (id_use_imm),
		.id_branch    (id_branch),
		.id_jal       (id_jal),
		.id_mem_read  (id_mem_read),
		.id_mem_write (id_mem_write),
		.id_reg_write (id_reg_write)
	);

	execute_unit i_execute_unit (
		.clock         (clock),
		.reset         (reset),
		.id_pc         (id_pc),
		.id_rs1        (id_rs1),
		.id_rs2        (id_rs2),
		.id_rd         (id_rd),
		.id_a          (id_a),
		.id_b          (id_b),
		.id_imm        (id_imm),
		.id_alu_op     (id_alu_op),
		.id_use_imm    (id_use_imm),
		.id_branch     (id_branch),
		.id_jal        (id_jal),
		.id_mem_read   (id_mem_read),
		.id_mem_write  (id_mem_write),
		.id_reg_write  (id_reg_write),
		.wb_rd         (wb_rd),
		.wb_we         (wb_we),
		.wb_data       (wb_data),
		.redirect      (redirect),
		.redirect_pc   (redirect_pc),
		.ex_result     (ex_result),
		.ex_store_data (data_out),
		.ex_rd         (ex_rd),
		.ex_reg_write  (ex_reg_write),
		.ex_mem_read   (ex_mem_read),
		.ex_mem_write  (wen)
	);

	writeback_unit i_writeback_unit (
		.clock        (clock),
		.reset        (reset),
		.ex_result    (ex_result),
		.ex_rd        (ex_rd),
		.ex_reg_write (ex_reg_write),
		.ex_mem_read  (ex_mem_read),
		.data_in      (data_in),
		.wb_rd        (wb_rd),
		.wb_we        (wb_we),
		.wb_data      (wb_data)
	);

endmodule

`default_nettype wire

// ==== logic/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_addr_t;

	localparam word_t initial_pc = 32'h0000_0000;

	// major opcodes of the supported subset
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;

	// funct3 values for register ops and beq
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;
	localparam logic [2:0] f3_beq     = 3'b000;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_t;

	// one instruction word, seen as R-type or I-type
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			reg_addr_t  rs2;
			reg_addr_t  rs1;
			logic [2:0] funct3;
			reg_addr_t  rd;
			logic [6:0] opcode;
		} r_fields;
		struct packed {
			logic [11:0] imm12;
			reg_addr_t   rs1;
			logic [2:0]  funct3;
			reg_addr_t   rd;
			logic [6:0]  opcode;
		} i_fields;
	} instr_u;

	// addi x0, x0, 0
	localparam word_t nop_instr = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== logic/writeback_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_unit (
	input  wire               clock,
	input  wire               reset,
	input  wire rv_pkg::word_t ex_result,
	input  wire rv_pkg::reg_addr_t ex_rd,
	input  wire               ex_reg_write,
	input  wire               ex_mem_read,
	input  wire rv_pkg::word_t data_in,
	output rv_pkg::reg_addr_t wb_rd,
	output logic              wb_we,
	output rv_pkg::word_t     wb_data
);

	logic          wb_load;
	rv_pkg::word_t load_data;
	rv_pkg::word_t alu_result;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			wb_we   <= 1'b0;
			wb_load <= 1'b0;
		end else begin
			wb_we   <= ex_reg_write;
			wb_load <= ex_mem_read;
		end
	end

	// read data arrives in the same cycle as the address
	always_ff @(posedge clock) begin
		wb_rd      <= ex_rd;
		load_data  <= data_in;
		alu_result <= ex_result;
	end

	assign wb_data = wb_load ? load_data : alu_result;

endmodule

`default_nettype wire

// ==== verif/rv_core_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_assertions (
	input wire                clock,
	input wire                reset,
	input wire rv_pkg::word_t pc,
	input wire                ren,
	input wire                wen
);

	// one instruction in the memory stage, never both strobes
	strobes_exclusive: assert property (@(posedge clock) disable iff (!reset)
		!(ren && wen))
		else $error("ren and wen are high in the same cycle");

	pc_aligned: assert property (@(posedge clock) disable iff (!reset)
		pc[1:0] == 2'b00)
		else $error("pc %h is not word aligned", pc);

	// pipeline holds only bubbles until the first fetch reaches memory
	quiet_after_reset: assert property (@(posedge clock) $rose(reset) |-> !wen [*3])
		else $error("wen is high before the first instruction can reach memory");

endmodule

bind rv_core rv_core_assertions i_rv_core_assertions (
	.clock (clock),
	.reset (reset),
	.pc    (pc),
	.ren   (ren),
	.wen   (wen)
);

`default_nettype wire

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

	logic          clock = 1'b0;
	logic          reset;
	rv_pkg::word_t pc;
	rv_pkg::word_t instr;
	rv_pkg::word_t data_addr;
	rv_pkg::word_t data_out;
	rv_pkg::word_t data_in;
	logic          ren;
	logic          wen;

	rv_pkg::word_t rom [64];
	rv_pkg::word_t ram [64];
	rv_pkg::word_t code [$];
	rv_pkg::word_t exp_addr [$];
	rv_pkg::word_t exp_data [$];
	logic          fill_request;
	logic          armed;
	logic [31:0]   lfsr_state;
	int            expected_count;
	int            store_count;
	int            load_expected;
	int            load_count;
	int            cycle_budget;
	int            error_count;
	int            failure_count;
	logic          timed_out;

	rv_core i_rv_core (
		.clock     (clock),
		.reset     (reset),
		.pc        (pc),
		.instr     (instr),
		.data_addr (data_addr),
		.data_out  (data_out),
		.data_in   (data_in),
		.ren       (ren),
		.wen       (wen)
	);

	always #10 clock = ~clock;

	// both memories answer in the same cycle
	assign instr   = rom[pc[7:2]];
	assign data_in = ren ? ram[data_addr[7:2]] : '0;

	always @(posedge clock) begin
		if (fill_request) begin
			for (int i = 0; i < 64; i++) begin
				ram[i[5:0]] <= ram_fill(i);
			end
		end else if (wen) begin
			ram[data_addr[7:2]] <= data_out;
		end
	end

	function automatic rv_pkg::word_t ram_fill(input int index);
		return {16'hd00d, 8'(index), 8'(~index)};
	endfunction

	// instruction encoders
	function automatic rv_pkg::word_t rr(input logic [6:0] f7, input logic [2:0] f3,
		input int rd, input int rs1, input int rs2);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_pkg::op_reg};
	endfunction

	function automatic rv_pkg::word_t addi(input int rd, input int rs1, input int imm);
		return {12'(imm), 5'(rs1), 3'b000, 5'(rd), rv_pkg::op_imm};
	endfunction

	function automatic rv_pkg::word_t lw(input int rd, input int rs1, input int imm);
		return {12'(imm), 5'(rs1), 3'b010, 5'(rd), rv_pkg::op_load};
	endfunction

	function automatic rv_pkg::word_t sw(input int src, input int base, input int imm);
		logic [11:0] v;
		v = 12'(imm);
		return {v[11:5], 5'(src), 5'(base), 3'b010, v[4:0], rv_pkg::op_store};
	endfunction

	function automatic rv_pkg::word_t beq(input int rs1, input int rs2, input int off);
		logic [12:0] v;
		v = 13'(off);
		return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'b000, v[4:1], v[11], rv_pkg::op_branch};
	endfunction

	function automatic rv_pkg::word_t jal(input int rd, input int off);
		logic [20:0] v;
		v = 21'(off);
		return {v[20], v[10:1], v[11], v[19:12], 5'(rd), rv_pkg::op_jal};
	endfunction

	function automatic logic lfsr_step();
		logic out_bit;
		out_bit = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out_bit) begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return out_bit;
	endfunction

	function automatic int random_field(input int width);
		int value;
		value = 0;
		for (int i = 0; i < width; i++) begin
			value = (value << 1) | int'(lfsr_step());
		end
		return value;
	endfunction

	// architectural model, runs the ROM until the jal self-loop
	function automatic int rv_model();
		rv_pkg::word_t regs [32];
		rv_pkg::word_t mem [64];
		rv_pkg::word_t pc_m;
		rv_pkg::word_t w;
		rv_pkg::word_t a;
		rv_pkg::word_t b;
		rv_pkg::word_t res;
		rv_pkg::word_t addr;
		rv_pkg::word_t imm_i;
		rv_pkg::word_t imm_s;
		rv_pkg::word_t imm_b;
		rv_pkg::word_t imm_j;
		rv_pkg::word_t next_pc;
		logic [4:0]    rd;
		logic          halted;
		exp_addr.delete();
		exp_data.delete();
		load_expected = 0;
		for (int i = 0; i < 32; i++) begin
			regs[i[4:0]] = '0;
		end
		for (int i = 0; i < 64; i++) begin
			mem[i[5:0]] = ram_fill(i);
		end
		pc_m = rv_pkg::initial_pc;
		halted = 1'b0;
		for (int step = 0; step < 2000 && !halted; step++) begin
			w = rom[pc_m[7:2]];
			rd = w[11:7];
			a = regs[w[19:15]];
			b = regs[w[24:20]];
			imm_i = {{20{w[31]}}, w[31:20]};
			imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
			imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			next_pc = pc_m + 32'd4;
			res = '0;
			case (w[6:0])
				rv_pkg::op_reg: begin
					case (w[14:12])
						3'b000: res = w[30] ? a - b : a + b;
						3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						3'b100: res = a ^ b;
						3'b110: res = a | b;
						3'b111: res = a & b;
						default: res = a + b;
					endcase
					regs[rd] = res;
				end
				rv_pkg::op_imm: regs[rd] = a + imm_i;
				rv_pkg::op_load: begin
					addr = a + imm_i;
					regs[rd] = mem[addr[7:2]];
					load_expected++;
				end
				rv_pkg::op_store: begin
					addr = a + imm_s;
					mem[addr[7:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				rv_pkg::op_branch: begin
					if (a == b) begin
						next_pc = pc_m + imm_b;
					end
				end
				rv_pkg::op_jal: begin
					regs[rd] = pc_m + 32'd4;
					next_pc = pc_m + imm_j;
					halted = (imm_j == '0);
				end
				default: begin
				end
			endcase
			regs[0] = '0;
			pc_m = next_pc;
		end
		return exp_addr.size();
	endfunction

	task automatic check_addr(input string name, input rv_pkg::word_t expected,
		input rv_pkg::word_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_data(input string name, input rv_pkg::word_t expected,
		input rv_pkg::word_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			error_count++;
			$display("[FAIL] %0t %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	// every store is matched against the model in order, read strobes are counted
	always @(posedge clock) begin
		if (!armed) begin
			store_count <= 0;
			load_count  <= 0;
		end else begin
			if (ren) begin
				load_count <= load_count + 1;
			end
			if (wen) begin
				if (store_count < expected_count) begin
					check_addr("data_addr", exp_addr[store_count], data_addr);
					check_data("data_out", exp_data[store_count], data_out);
				end else begin
					failure_count++;
					$display("unexpected store of %h to %h after the last expected store",
						data_out, data_addr);
				end
				store_count <= store_count + 1;
			end
		end
	end

	task automatic emit(input rv_pkg::word_t w);
		code.push_back(w);
	endtask

	task automatic load_rom();
		for (int i = 0; i < 64; i++) begin
			if (i < code.size()) begin
				rom[i[5:0]] = code[i];
			end else begin
				// addi x0 filler, varies with the address
				rom[i[5:0]] = addi(0, 0, i);
			end
		end
	endtask

	task automatic run_program(input string name);
		cycle_budget += code.size() * 4;
		@(posedge clock);
		reset <= 1'b0;
		armed <= 1'b0;
		fill_request <= 1'b1;
		@(negedge clock);
		load_rom();
		expected_count = rv_model();
		$display("running %s with %0d expected stores", name, expected_count);
		@(posedge clock);
		fill_request <= 1'b0;
		@(posedge clock);
		reset <= 1'b1;
		armed <= 1'b1;
		while (store_count < expected_count) begin
			@(posedge clock);
		end
		// nothing more may be stored once the program sits in its loop
		repeat (20) @(posedge clock);
		check_count("ren", load_expected, load_count);
		armed <= 1'b0;
	endtask

	task automatic chain_program();
		code.delete();
		emit(addi(1, 0, 1445));
		emit(addi(2, 1, -291));
		emit(rr(7'h00, rv_pkg::f3_add_sub, 3, 1, 2));
		emit(rr(7'h20, rv_pkg::f3_add_sub, 4, 3, 1));
		emit(rr(7'h00, rv_pkg::f3_and, 5, 3, 2));
		emit(rr(7'h00, rv_pkg::f3_or, 6, 4, 5));
		emit(rr(7'h00, rv_pkg::f3_xor, 7, 6, 1));
		emit(rr(7'h00, rv_pkg::f3_slt, 8, 2, 1));
		emit(addi(9, 0, -5));
		emit(rr(7'h00, rv_pkg::f3_slt, 10, 9, 7));
		emit(rr(7'h00, rv_pkg::f3_slt, 11, 1, 9));
		for (int r = 1; r <= 11; r++) begin
			emit(sw(r, 0, 4 * r));
		end
		emit(jal(0, 0));
	endtask

	task automatic load_use_program();
		code.delete();
		emit(addi(1, 0, 100));
		emit(sw(1, 0, 8));
		emit(lw(2, 0, 8));
		emit(rr(7'h00, rv_pkg::f3_add_sub, 3, 2, 1));
		emit(sw(3, 0, 12));
		emit(lw(4, 0, 16));
		emit(addi(5, 4, 1));
		emit(sw(5, 0, 20));
		emit(lw(6, 0, 8));
		emit(sw(6, 0, 24));
		emit(jal(0, 0));
	endtask

	// counts x1 down from 5, the two sw after the back branch never run
	task automatic branch_loop_program();
		code.delete();
		emit(addi(1, 0, 5));
		emit(addi(2, 0, 0));
		emit(sw(1, 2, 32));
		emit(addi(2, 2, 4));
		emit(addi(1, 1, -1));
		emit(beq(1, 0, 16));
		emit(beq(0, 0, -16));
		emit(sw(0, 0, 0));
		emit(sw(0, 0, 4));
		emit(sw(2, 0, 60));
		emit(jal(0, 0));
	endtask

	task automatic jal_skip_program();
		code.delete();
		emit(addi(1, 0, 33));
		emit(jal(5, 12));
		emit(sw(1, 0, 0));
		emit(sw(1, 0, 4));
		emit(sw(5, 0, 8));
		emit(sw(1, 0, 12));
		emit(jal(0, 0));
	endtask

	task automatic random_program(input int count);
		int kind;
		int rd;
		int rs1;
		int rs2;
		int imm;
		code.delete();
		for (int j = 0; j < count; j++) begin
			kind = random_field(3);
			rd = random_field(5);
			rs1 = random_field(5);
			rs2 = random_field(5);
			imm = random_field(12);
			case (kind)
				0: emit(rr(7'h00, rv_pkg::f3_add_sub, rd, rs1, rs2));
				1: emit(rr(7'h20, rv_pkg::f3_add_sub, rd, rs1, rs2));
				2: emit(rr(7'h00, rv_pkg::f3_and, rd, rs1, rs2));
				3: emit(rr(7'h00, rv_pkg::f3_or, rd, rs1, rs2));
				4: emit(rr(7'h00, rv_pkg::f3_xor, rd, rs1, rs2));
				5: emit(rr(7'h00, rv_pkg::f3_slt, rd, rs1, rs2));
				default: emit(addi(rd, rs1, imm));
			endcase
			emit(sw(rd, 0, 4 * j));
		end
		emit(jal(0, 0));
	endtask

	task automatic close_run();
		$display("run complete: %0d value errors, %0d other failures",
			error_count, failure_count + (timed_out ? 1 : 0));
		if (error_count == 0 && failure_count == 0 && !timed_out) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	endtask

	initial begin : watchdog
		int cycles;
		cycles = 0;
		timed_out = 1'b0;
		while (cycles <= cycle_budget + 200) begin
			@(posedge clock);
			cycles++;
		end
		timed_out = 1'b1;
		$display("timeout: the core did not finish its stores within %0d cycles", cycles);
		close_run();
	end

	initial begin : stimulus
		reset <= 1'b0;
		armed <= 1'b0;
		fill_request <= 1'b0;
		lfsr_state = 32'h197106e2;
		expected_count = 0;
		load_expected = 0;
		cycle_budget = 0;
		error_count = 0;
		failure_count = 0;
		code.delete();
		load_rom();
		chain_program();
		run_program("dependent ALU chain");
		load_use_program();
		run_program("load-use");
		branch_loop_program();
		run_program("beq countdown loop");
		jal_skip_program();
		run_program("jal skip");
		// 40 random ops in two ROM-sized batches
		random_program(20);
		run_program("random batch one");
		random_program(20);
		run_program("random batch two");
		close_run();
	end

endmodule

`default_nettype wire
